// File: hdl/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    localparam int WORD_W = 16;
    localparam int REG_W = 3;
    localparam int OPCODE_W = 4;

    typedef logic [WORD_W-1:0] lc3b_word_t;
    typedef logic [REG_W-1:0] lc3b_reg_t;

    // values follow instruction bits 15 to 12.
    typedef enum logic [OPCODE_W-1:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode_e;

    // The all-zero value of this word is a bubble.
    typedef struct packed {
        lc3b_opcode_e opcode;
        logic         reg_write;  // jsr and trap also write r7.
        logic         mem_read;
        logic         mem_write;
        logic         use_imm;
        logic         is_branch;  // any change of flow, rti included.
    } lc3b_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

    logic                valid;
    logic                ready;
    lc3b_pkg::lc3b_word_t pc;     // byte address of instr.
    lc3b_pkg::lc3b_word_t instr;

    modport source (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    modport sink (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter lc3b_pkg::lc3b_word_t RESET_PC = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output lc3b_pkg::lc3b_word_t wb_adr,
    input  lc3b_pkg::lc3b_word_t wb_dat_i,
    input  logic                 wb_ack,
    fetch_if.source              out
);

    logic                 busy;        // a read cycle is open on the bus.
    logic                 hold_valid;
    logic                 start;
    logic                 done;
    lc3b_pkg::lc3b_word_t pc;
    lc3b_pkg::lc3b_word_t hold_pc;
    lc3b_pkg::lc3b_word_t hold_instr;

    // The hold must be able to take the result, so a cycle opens only
    // when it is empty or gives up its word on this edge.
    assign start = !busy && (!hold_valid || out.ready);
    assign done = busy && wb_ack;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            pc <= RESET_PC;
        end
        else if (done)
        begin
            busy <= 1'b0;  // cyc drops on the cycle after ack.
            pc <= pc + 16'd2;
        end
        else if (start)
        begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hold_valid <= 1'b0;
        end
        else if (done)
        begin
            hold_valid <= 1'b1;
        end
        else if (out.ready)
        begin
            hold_valid <= 1'b0;
        end
    end

    // the hold is empty whenever ack arrives, so it can load unconditionally.
    always_ff @(posedge clk)
    begin
        if (done)
        begin
            hold_pc <= pc;
            hold_instr <= wb_dat_i;
        end
    end

    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_adr = pc;

    assign out.valid = hold_valid;
    assign out.pc = hold_pc;
    assign out.instr = hold_instr;

endmodule

`default_nettype wire

// File: hdl/ifid_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ifid_reg (
    input  logic  clk,
    input  logic  rst_n,
    fetch_if.sink   in,
    fetch_if.source out
);

    logic                 full;
    logic                 accept;
    lc3b_pkg::lc3b_word_t pc_q;
    lc3b_pkg::lc3b_word_t instr_q;

    // A full entry that drains on this edge can be refilled at once,
    // which keeps one item per cycle flowing.
    assign in.ready = !full || out.ready;
    assign accept = in.valid && in.ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            full <= 1'b0;
        end
        else if (accept)
        begin
            full <= 1'b1;
        end
        else if (out.ready)
        begin
            full <= 1'b0;  // drained with nothing behind it.
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            pc_q <= in.pc;
            instr_q <= in.instr;
        end
    end

    assign out.valid = full;
    assign out.pc = pc_q;
    assign out.instr = instr_q;

endmodule

`default_nettype wire

// File: hdl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    fetch_if.sink                in,
    output logic                 out_valid,
    input  logic                 out_ready,
    output lc3b_pkg::lc3b_word_t out_pc,
    output lc3b_pkg::lc3b_ctrl_t out_ctrl,
    output lc3b_pkg::lc3b_reg_t  out_dest,
    output lc3b_pkg::lc3b_reg_t  out_src1,
    output lc3b_pkg::lc3b_reg_t  out_src2,
    output lc3b_pkg::lc3b_word_t out_imm,
    output lc3b_pkg::lc3b_word_t out_trapvect
);

    logic                    accept;
    logic                    bubble;
    lc3b_pkg::lc3b_word_t    instr;
    lc3b_pkg::lc3b_opcode_e  opcode;
    lc3b_pkg::lc3b_ctrl_t    ctrl_d;
    lc3b_pkg::lc3b_word_t    imm_d;

    assign instr = in.instr;
    assign opcode = lc3b_pkg::lc3b_opcode_e'(instr[15:12]);
    assign bubble = (instr == 16'h0000);  // br with no condition bits.

    always_comb
    begin
        ctrl_d = '0;
        imm_d = '0;
        ctrl_d.opcode = opcode;
        case (opcode)
            lc3b_pkg::op_add, lc3b_pkg::op_and:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.use_imm = instr[5];
                imm_d = {{11{instr[4]}}, instr[4:0]};
            end
            lc3b_pkg::op_not:
                ctrl_d.reg_write = 1'b1;
            lc3b_pkg::op_shf:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.use_imm = 1'b1;
                imm_d = {12'h000, instr[3:0]};  // shift amount is unsigned.
            end
            lc3b_pkg::op_ldb, lc3b_pkg::op_ldr:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.mem_read = 1'b1;
                imm_d = {{10{instr[5]}}, instr[5:0]};
            end
            lc3b_pkg::op_stb, lc3b_pkg::op_str:
            begin
                ctrl_d.mem_write = 1'b1;
                imm_d = {{10{instr[5]}}, instr[5:0]};
            end
            lc3b_pkg::op_ldi:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.mem_read = 1'b1;
                imm_d = {{7{instr[8]}}, instr[8:0]};
            end
            lc3b_pkg::op_sti:
            begin
                ctrl_d.mem_write = 1'b1;
                imm_d = {{7{instr[8]}}, instr[8:0]};
            end
            lc3b_pkg::op_lea:
            begin
                ctrl_d.reg_write = 1'b1;
                imm_d = {{7{instr[8]}}, instr[8:0]};
            end
            lc3b_pkg::op_br:
            begin
                ctrl_d.is_branch = 1'b1;
                imm_d = {{7{instr[8]}}, instr[8:0]};
            end
            lc3b_pkg::op_jsr:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.is_branch = 1'b1;
                // jsrr takes its target from a register and has no offset.
                if (instr[11])
                    imm_d = {{5{instr[10]}}, instr[10:0]};
            end
            lc3b_pkg::op_trap:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.is_branch = 1'b1;
            end
            default:
                ctrl_d.is_branch = 1'b1;  // jmp and rti.
        endcase
    end

    assign in.ready = !out_valid || out_ready;
    assign accept = in.valid && in.ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_pc <= in.pc;
            out_ctrl <= bubble ? '0 : ctrl_d;  // a zero word would decode as br.
            out_dest <= instr[11:9];
            out_src1 <= instr[8:6];
            out_src2 <= instr[2:0];
            out_imm <= imm_d;
            out_trapvect <= {7'd0, instr[7:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: hdl/lc3b_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend #(
    parameter lc3b_pkg::lc3b_word_t RESET_PC = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output lc3b_pkg::lc3b_word_t wb_adr,
    input  lc3b_pkg::lc3b_word_t wb_dat_i,
    input  logic                 wb_ack,
    output logic                 out_valid,
    input  logic                 out_ready,
    output lc3b_pkg::lc3b_word_t out_pc,
    output lc3b_pkg::lc3b_ctrl_t out_ctrl,
    output lc3b_pkg::lc3b_reg_t  out_dest,
    output lc3b_pkg::lc3b_reg_t  out_src1,
    output lc3b_pkg::lc3b_reg_t  out_src2,
    output lc3b_pkg::lc3b_word_t out_imm,
    output lc3b_pkg::lc3b_word_t out_trapvect
);

    fetch_if if_link ();
    fetch_if id_link ();  // carries the raw word, decode happens downstream.

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .out      (if_link)
    );

    ifid_reg ifid_reg_i (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (if_link),
        .out   (id_link)
    );

    decode_unit decode_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (id_link),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_ctrl     (out_ctrl),
        .out_dest     (out_dest),
        .out_src1     (out_src1),
        .out_src2     (out_src2),
        .out_imm      (out_imm),
        .out_trapvect (out_trapvect)
    );

endmodule

`default_nettype wire

// File: sim/lc3b_frontend_properties.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input lc3b_pkg::lc3b_word_t wb_adr,
    input logic                 wb_ack,
    input logic                 out_valid,
    input logic                 out_ready,
    input lc3b_pkg::lc3b_word_t out_pc,
    input lc3b_pkg::lc3b_ctrl_t out_ctrl,
    input lc3b_pkg::lc3b_reg_t  out_dest,
    input lc3b_pkg::lc3b_reg_t  out_src1,
    input lc3b_pkg::lc3b_reg_t  out_src2,
    input lc3b_pkg::lc3b_word_t out_imm,
    input lc3b_pkg::lc3b_word_t out_trapvect
);

    int unsigned failures = 0;  // read by the testbench.

    stb_follows_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb == wb_cyc)
    else
    begin
        failures++;
        $error("wb_stb differs from wb_cyc.");
    end

    // a waiting cycle keeps cyc high and the address steady.
    adr_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
    else
    begin
        failures++;
        $error("wb_adr or wb_cyc changed before ack.");
    end

    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable({out_pc, out_ctrl,
            out_dest, out_src1, out_src2, out_imm, out_trapvect}))
    else
    begin
        failures++;
        $error("output item changed during a stall.");
    end

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_cyc && !out_valid)
    else
    begin
        failures++;
        $error("bus or output active right after reset.");
    end

endmodule

bind lc3b_frontend lc3b_frontend_properties properties_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_ack       (wb_ack),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_pc       (out_pc),
    .out_ctrl     (out_ctrl),
    .out_dest     (out_dest),
    .out_src1     (out_src1),
    .out_src2     (out_src2),
    .out_imm      (out_imm),
    .out_trapvect (out_trapvect)
);

`default_nettype wire

// File: sim/lc3b_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend_tb;

    localparam lc3b_pkg::lc3b_word_t BASE_PC = 16'h3000;
    localparam int ROWS = 14;
    localparam int MEM_WORDS = 32;
    localparam int TIMEOUT = 100;  // cycles allowed for any single wait.

    typedef struct packed {
        logic [15:0] instr;
        logic [8:0]  ctrl;  // {opcode, reg_write, mem_read, mem_write, use_imm, is_branch}
        logic [2:0]  dest;
        logic [2:0]  src1;
        logic [2:0]  src2;
        logic [15:0] imm;
        logic [15:0] trapvect;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_ack;
    logic                 out_valid;
    logic                 out_ready;
    lc3b_pkg::lc3b_word_t wb_adr;
    lc3b_pkg::lc3b_word_t wb_dat_i;
    lc3b_pkg::lc3b_word_t out_pc;
    lc3b_pkg::lc3b_word_t out_imm;
    lc3b_pkg::lc3b_word_t out_trapvect;
    lc3b_pkg::lc3b_ctrl_t out_ctrl;
    lc3b_pkg::lc3b_reg_t  out_dest;
    lc3b_pkg::lc3b_reg_t  out_src1;
    lc3b_pkg::lc3b_reg_t  out_src2;
    row_t                 rows [ROWS];
    lc3b_pkg::lc3b_word_t mem [MEM_WORDS];
    int                   wait_left;

    lc3b_frontend #(
        .RESET_PC (16'h3000)
    ) lc3b_frontend_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_ctrl     (out_ctrl),
        .out_dest     (out_dest),
        .out_src1     (out_src1),
        .out_src2     (out_src2),
        .out_imm      (out_imm),
        .out_trapvect (out_trapvect)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure.");
    endtask

    task automatic report_mismatch(input string what, input logic [15:0] got,
                                   input logic [15:0] expected);
        abort_run($sformatf("** Error at time %0t: %s is %h, expected %h",
                            $time, what, got, expected));
    endtask

    task automatic load_table();
        // instr, ctrl, dest, src1, src2, imm, trapvect
        rows[0]  = '{16'h1283, {4'h1, 5'b10000}, 3'd1, 3'd2, 3'd3, 16'h0003, 16'h0106};
        rows[1]  = '{16'h197d, {4'h1, 5'b10010}, 3'd4, 3'd5, 3'd5, 16'hfffd, 16'h00fa};
        rows[2]  = '{16'h51a7, {4'h5, 5'b10010}, 3'd0, 3'd6, 3'd7, 16'h0007, 16'h014e};
        rows[3]  = '{16'h5e42, {4'h5, 5'b10000}, 3'd7, 3'd1, 3'd2, 16'h0002, 16'h0084};
        rows[4]  = '{16'h94ff, {4'h9, 5'b10000}, 3'd2, 3'd3, 3'd7, 16'h0000, 16'h01fe};
        rows[5]  = '{16'hd705, {4'hd, 5'b10010}, 3'd3, 3'd4, 3'd5, 16'h0005, 16'h000a};
        rows[6]  = '{16'h6bbe, {4'h6, 5'b11000}, 3'd5, 3'd6, 3'd6, 16'hfffe, 16'h017c};
        rows[7]  = '{16'h7284, {4'h7, 5'b00100}, 3'd1, 3'd2, 3'd4, 16'h0004, 16'h0108};
        rows[8]  = '{16'h0000, {4'h0, 5'b00000}, 3'd0, 3'd0, 3'd0, 16'h0000, 16'h0000};
        rows[9]  = '{16'hedf0, {4'he, 5'b10000}, 3'd6, 3'd7, 3'd0, 16'hfff0, 16'h01e0};
        rows[10] = '{16'h4c00, {4'h4, 5'b10001}, 3'd6, 3'd0, 3'd0, 16'hfc00, 16'h0000};
        rows[11] = '{16'hc0c0, {4'hc, 5'b00001}, 3'd0, 3'd3, 3'd0, 16'h0000, 16'h0180};
        rows[12] = '{16'hf025, {4'hf, 5'b10001}, 3'd0, 3'd0, 3'd5, 16'h0000, 16'h004a};
        rows[13] = '{16'h0e05, {4'h0, 5'b00001}, 3'd7, 3'd0, 3'd5, 16'h0005, 16'h000a};
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (i < ROWS) ? rows[i].instr : ~(BASE_PC + 16'(2 * i));
    endtask

    function automatic lc3b_pkg::lc3b_word_t read_word(input lc3b_pkg::lc3b_word_t addr);
        int idx;
        idx = (int'(addr) - int'(BASE_PC)) / 2;
        if (addr >= BASE_PC && idx < MEM_WORDS)
            return mem[idx];
        return ~addr;  // words past the table still depend on the full address.
    endfunction

    // wishbone slave with 0 to 3 wait states per cycle.
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack <= 1'b0;
            wait_left <= $urandom_range(3);
        end
        else
        begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack)
            begin
                if (wait_left == 0)
                begin
                    wb_ack <= 1'b1;
                    wb_dat_i <= read_word(wb_adr);
                    wait_left <= $urandom_range(3);
                end
                else
                    wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (!rst_n)
            out_ready <= 1'b0;
        else
            out_ready <= ($urandom_range(3) != 0);  // stalls about one cycle in four.
    end

    always @(negedge clk)
    begin
        if (lc3b_frontend_i.properties_i.failures != 0)
            abort_run("A bound protocol assertion failed, see the message above.");
    end

    task automatic wait_for_output(input int row);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(out_valid && out_ready))
        begin
            cycles++;
            if (cycles > TIMEOUT)
                abort_run($sformatf("Timed out waiting for output item %0d.", row));
            @(negedge clk);
        end
    endtask

    task automatic check_row(input int row);
        lc3b_pkg::lc3b_word_t exp_pc;
        string tag;
        exp_pc = BASE_PC + 16'(2 * row);
        tag = $sformatf("row %0d", row);
        assert (out_pc == exp_pc) else report_mismatch({tag, " pc"}, out_pc, exp_pc);
        assert (out_ctrl == rows[row].ctrl)
            else report_mismatch({tag, " ctrl"}, out_ctrl, rows[row].ctrl);
        assert (out_dest == rows[row].dest)
            else report_mismatch({tag, " dest"}, out_dest, rows[row].dest);
        assert (out_src1 == rows[row].src1)
            else report_mismatch({tag, " src1"}, out_src1, rows[row].src1);
        assert (out_src2 == rows[row].src2)
            else report_mismatch({tag, " src2"}, out_src2, rows[row].src2);
        assert (out_imm == rows[row].imm)
            else report_mismatch({tag, " imm"}, out_imm, rows[row].imm);
        assert (out_trapvect == rows[row].trapvect)
            else report_mismatch({tag, " trapvect"}, out_trapvect, rows[row].trapvect);
    endtask

    initial
    begin
        int cycles;
        void'($urandom(32'h46f8));
        rst_n = 1'b0;
        out_ready = 1'b0;
        wb_ack = 1'b0;
        wb_dat_i = 16'h0000;
        load_table();
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            assert (!wb_cyc && !out_valid)
                else abort_run($sformatf("** Error at time %0t: bus or output active in reset",
                                         $time));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!wb_cyc && !out_valid)
            else abort_run($sformatf("** Error at time %0t: bus or output active after reset",
                                     $time));
        cycles = 0;
        while (!wb_cyc)
        begin
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("Timed out waiting for the first bus cycle.");
            @(negedge clk);
        end
        assert (wb_adr == BASE_PC) else report_mismatch("first wb_adr", wb_adr, BASE_PC);
        for (int row = 0; row < ROWS; row++)
        begin
            wait_for_output(row);
            check_row(row);
            @(posedge clk);  // the item is taken on this edge.
        end
        if (lc3b_frontend_i.properties_i.failures == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
            abort_run("A bound protocol assertion failed during the run.");
    end

endmodule

`default_nettype wire

// File: project.f
hdl/lc3b_pkg.sv
hdl/fetch_if.sv
hdl/fetch_unit.sv
hdl/ifid_reg.sv
hdl/decode_unit.sv
hdl/lc3b_frontend.sv
sim/lc3b_frontend_properties.sv
sim/lc3b_frontend_tb.sv
